// ==== tb.f ====
rtl/quant_pkg.sv
rtl/acc_vec_if.sv
rtl/scale_bias_cfg.sv
rtl/bias_add_vec.sv
rtl/quan_relu_scale_vec.sv
rtl/quant_out_stage.sv
verification/tb_clock_gen.sv
verification/quant_out_stage_assertions.sv
verification/tb_quant_out_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the quantizer output stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_quant_out_stage -o sim_quant_out_stage

# the log decides the result, so the run status itself is not used
./obj_dir/sim_quant_out_stage +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation did not pass"
  exit 1
fi

// ==== verification/tb_quant_out_stage.sv ====
`timescale 1ns/10ps

module tb_quant_out_stage;

  localparam int rand_seed = 38747;
  localparam int reset_cycles = 16;
  localparam int out_valid_timeout = 20;

  logic clk;
  logic reset;
  logic cfg_load;
  logic [15:0] cfg_scale;
  quant_pkg::bias_pair_t cfg_bias;
  logic acc_valid;
  quant_pkg::mode_t acc_mode;
  logic acc_last;
  logic [quant_pkg::acc_vec_width-1:0] acc_vector;
  logic out_valid;
  logic out_last;
  logic [quant_pkg::quant_vec_width-1:0] out_vector;

  // configuration as the model sees it
  logic [15:0] model_scale;
  quant_pkg::bias_pair_t model_bias;
  int unsigned cycle = 0;
  int value_errors = 0;
  int other_errors = 0;

  tb_clock_gen u_clk (.clk(clk));

  quant_out_stage u_dut (.*);

  always @(posedge clk) cycle <= cycle + 1;

  //////////////////////////////////////////////////////////////////////
  // reference model and compares
  //////////////////////////////////////////////////////////////////////

  // bias add with 40-bit wrap, relu, shift, clamp to 255
  function automatic logic [quant_pkg::quant_vec_width-1:0] model_vector(
    input logic [quant_pkg::acc_vec_width-1:0] vec,
    input quant_pkg::mode_t mode
  );
    logic [quant_pkg::quant_vec_width-1:0] res;
    longint sum;
    int ch;
    res = '0;
    for (int lane = 0; lane < quant_pkg::lane_num; lane++) begin
      ch = lane / quant_pkg::lanes_per_channel;
      if (mode == quant_pkg::mode_dual_ch || (mode == quant_pkg::mode_single_ch && ch == 0)) begin
        sum = longint'($signed(vec[lane*quant_pkg::acc_width +: quant_pkg::acc_width]));
        sum += (ch == 1) ? model_bias.bias_ch1 : model_bias.bias_ch0;
        sum = longint'($signed(sum[quant_pkg::acc_width-1:0]));
        if (sum < 0) sum = 0;
        sum = sum >> ((ch == 1) ? model_scale[15:8] : model_scale[7:0]);
        res[lane*quant_pkg::quant_width +: quant_pkg::quant_width] = (sum > 255) ? 8'd255 : sum[7:0];
      end
    end
    return res;
  endfunction

  task automatic compare_quant_vector(input string test,
      input logic [quant_pkg::quant_vec_width-1:0] expected, actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[ERROR] %s: expected %h, actual %h", test, expected, actual);
    end
  endtask

  task automatic compare_flag(input string test, input logic expected, actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[ERROR] %s: expected %b, actual %b", test, expected, actual);
    end
  endtask

  // lanes in a modest signed range so all clamp cases show up
  function automatic logic [quant_pkg::acc_vec_width-1:0] random_vector();
    logic [quant_pkg::acc_vec_width-1:0] vec;
    logic [19:0] r;
    for (int lane = 0; lane < quant_pkg::lane_num; lane++) begin
      r = 20'($urandom);
      vec[lane*quant_pkg::acc_width +: quant_pkg::acc_width] =
          {{(quant_pkg::acc_width - 20){r[19]}}, r};
    end
    return vec;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_vector(input logic [quant_pkg::acc_vec_width-1:0] vec,
      input quant_pkg::mode_t mode, input logic last);
    @(posedge clk);
    #0.5;
    acc_valid = 1'b1;
    acc_mode = mode;
    acc_last = last;
    acc_vector = vec;
  endtask

  task automatic go_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #0.5;
      acc_valid = 1'b0;
      acc_last = 1'b0;
      cfg_load = 1'b0;
    end
  endtask

  task automatic wait_out_valid(output bit seen);
    int waited;
    seen = 1'b0;
    waited = 0;
    while (!seen && waited < out_valid_timeout) begin
      @(posedge clk);
      #0.5;
      seen = out_valid;
      waited++;
    end
    if (!seen) begin
      $display("timed out waiting for out_valid");
      other_errors++;
    end
  endtask

  task automatic send_and_check(input string test,
      input logic [quant_pkg::acc_vec_width-1:0] vec,
      input quant_pkg::mode_t mode, input logic last);
    logic [quant_pkg::quant_vec_width-1:0] expected;
    bit seen;
    expected = model_vector(vec, mode);
    drive_vector(vec, mode, last);
    go_idle(1);
    wait_out_valid(seen);
    if (seen) begin
      compare_quant_vector(test, expected, out_vector);
      compare_flag(test, last, out_last);
    end
  endtask

  task automatic load_config(input logic [15:0] scale,
      input logic signed [15:0] bias_ch1, bias_ch0);
    @(posedge clk);
    #0.5;
    cfg_load = 1'b1;
    cfg_scale = scale;
    cfg_bias.bias_ch1 = bias_ch1;
    cfg_bias.bias_ch0 = bias_ch0;
    model_scale = scale;
    model_bias = cfg_bias;
    // load edge, then two quiet cycles
    go_idle(3);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    compare_flag("reset valid", 1'b0, out_valid);
    compare_flag("reset last", 1'b0, out_last);
    compare_quant_vector("reset vector", '0, out_vector);
  endtask

  task automatic test_dual_channel();
    // negative, zero, in range, exactly 255, overflow for each channel
    int lanes [10] = '{0, 1, 2, 3, 4, 32, 33, 34, 35, 36};
    longint picks [10] = '{-1000, -16, 1000, 4064, 100000, 1028, -5, 8, 1073741824, 500};
    logic [quant_pkg::acc_vec_width-1:0] vec;
    load_config({8'd2, 8'd4}, -16'sd8, 16'sd16);
    vec = random_vector();
    foreach (lanes[i]) begin
      vec[lanes[i]*quant_pkg::acc_width +: quant_pkg::acc_width] = picks[i][39:0];
    end
    send_and_check("dual channel", vec, quant_pkg::mode_dual_ch, 1'b1);
  endtask

  task automatic test_single_channel();
    // upper byte 0xab is not a shift in this mode
    load_config(16'hab03, 16'sd1000, -16'sd4);
    send_and_check("single channel", random_vector(), quant_pkg::mode_single_ch, 1'b0);
    send_and_check("mode 3", random_vector(), quant_pkg::mode_t'(4'd3), 1'b1);
  endtask

  task automatic test_streaming();
    logic [quant_pkg::quant_vec_width-1:0] exp_q[$];
    logic last_q[$];
    int unsigned accept_q[$];
    logic [quant_pkg::acc_vec_width-1:0] vec;
    quant_pkg::mode_t mode;
    logic last;
    bit seen;
    fork
      begin
        for (int i = 0; i < 20; i++) begin
          vec = random_vector();
          mode = quant_pkg::mode_t'($urandom_range(1, 0));
          last = 1'($urandom_range(1, 0));
          exp_q.push_back(model_vector(vec, mode));
          last_q.push_back(last);
          drive_vector(vec, mode, last);
          // edge the vector is driven after
          accept_q.push_back(cycle);
        end
        go_idle(1);
      end
      begin
        for (int i = 0; i < 20; i++) begin
          wait_out_valid(seen);
          if (!seen) break;
          if (cycle != accept_q.pop_front() + 2) begin
            $display("stream vector %0d did not come out two cycles after its input", i);
            other_errors++;
          end
          compare_quant_vector("streaming vector", exp_q.pop_front(), out_vector);
          compare_flag("streaming last", last_q.pop_front(), out_last);
        end
      end
    join
  endtask

  task automatic test_hold_reconfig();
    logic [quant_pkg::quant_vec_width-1:0] held;
    held = out_vector;
    go_idle(3);
    compare_quant_vector("hold vector", held, out_vector);
    compare_flag("hold valid", 1'b0, out_valid);
    load_config({8'd1, 8'd6}, 16'sd300, -16'sd50);
    // new scales must not reach the idle output register
    compare_quant_vector("hold over reload", held, out_vector);
    send_and_check("reconfig", random_vector(), quant_pkg::mode_dual_ch, 1'b1);
  endtask

  initial begin
    int assert_fails;
    void'($urandom(rand_seed));
    reset = 1'b1;
    cfg_load = 1'b0;
    cfg_scale = '0;
    cfg_bias = '0;
    acc_valid = 1'b0;
    acc_mode = quant_pkg::mode_single_ch;
    acc_last = 1'b0;
    acc_vector = '0;
    model_scale = '0;
    model_bias = '0;
    repeat (reset_cycles) @(posedge clk);
    #0.5;
    reset = 1'b0;

    test_reset();
    test_dual_channel();
    test_single_channel();
    test_streaming();
    test_hold_reconfig();

    assert_fails = u_dut.u_assertions.failures;
    $display("errors: %0d value, %0d other, %0d assertion",
             value_errors, other_errors, assert_fails);
    if (value_errors + other_errors + assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== verification/quant_out_stage_assertions.sv ====
`timescale 1ns/10ps

module quant_out_stage_assertions (
  input logic clk,
  input logic reset,
  input logic acc_valid,
  input logic out_valid,
  input logic out_last
);

  // failed assertions, read by the testbench at the end of the run
  int failures = 0;

  // fixed two-stage pipeline, one vector per cycle
  valid_latency: assert property (@(posedge clk) disable iff (reset)
    out_valid == $past(acc_valid, 2))
    else begin
      $error("out_valid does not follow acc_valid by two cycles");
      failures++;
    end

  last_needs_valid: assert property (@(posedge clk) disable iff (reset)
    out_last |-> out_valid)
    else begin
      $error("out_last high without out_valid");
      failures++;
    end

  valid_low_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      $error("out_valid high after a reset cycle");
      failures++;
    end

endmodule

bind quant_out_stage quant_out_stage_assertions u_assertions (
  .clk       (clk),
  .reset     (reset),
  .acc_valid (acc_valid),
  .out_valid (out_valid),
  .out_last  (out_last)
);

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/10ps

// free-running testbench clock, 4 ns period
module tb_clock_gen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

endmodule

// ==== rtl/quant_out_stage.sv ====
`timescale 1ns/10ps

module quant_out_stage (
  input  logic clk,
  input  logic reset,
  // configuration
  input  logic cfg_load,
  input  logic [$bits(quant_pkg::scale_word_u)-1:0] cfg_scale,
  input  logic [$bits(quant_pkg::bias_pair_t)-1:0] cfg_bias,
  // accumulator vector from the array
  input  logic acc_valid,
  input  quant_pkg::mode_t acc_mode,
  input  logic acc_last,
  input  logic [quant_pkg::acc_vec_width-1:0] acc_vector,
  // quantized vector
  output logic out_valid,
  output logic out_last,
  output logic [quant_pkg::quant_vec_width-1:0] out_vector
);

  acc_vec_if acc_if ();

  quant_pkg::bias_pair_t cur_bias;
  logic [quant_pkg::scale_width-1:0] scale_ch0;
  logic [quant_pkg::scale_width-1:0] scale_ch1;

  //////////////////////////////////////////////////////////////////////
  // configuration path
  //////////////////////////////////////////////////////////////////////

  // scale decode tracks the mode in the quantizer stage
  scale_bias_cfg u_cfg (
    .clk       (clk),
    .reset     (reset),
    .load      (cfg_load),
    .scale_in  (cfg_scale),
    .bias_in   (cfg_bias),
    .mode      (acc_if.mode),
    .scale_ch0 (scale_ch0),
    .scale_ch1 (scale_ch1),
    .cur_bias  (cur_bias)
  );

  //////////////////////////////////////////////////////////////////////
  // data path, two stages
  //////////////////////////////////////////////////////////////////////

  bias_add_vec u_bias_add (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (acc_valid),
    .in_mode   (acc_mode),
    .in_last   (acc_last),
    .in_vector (acc_vector),
    .bias      (cur_bias),
    .out       (acc_if.producer)
  );

  quan_relu_scale_vec u_quant (
    .clk        (clk),
    .reset      (reset),
    .in         (acc_if.consumer),
    .scale_ch0  (scale_ch0),
    .scale_ch1  (scale_ch1),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .out_vector (out_vector)
  );

endmodule

// ==== rtl/quan_relu_scale_vec.sv ====
`timescale 1ns/10ps

module quan_relu_scale_vec (
  input  logic clk,
  input  logic reset,
  acc_vec_if.consumer in,
  input  logic [quant_pkg::scale_width-1:0] scale_ch0,
  input  logic [quant_pkg::scale_width-1:0] scale_ch1,
  output logic out_valid,
  output logic out_last,
  output logic [quant_pkg::quant_vec_width-1:0] out_vector
);

  logic [quant_pkg::quant_vec_width-1:0] quant_vector;
  logic lower_live;
  logic upper_live;

  // relu, logical shift, clamp to 8 unsigned bits
  function automatic logic [quant_pkg::quant_width-1:0] quantize_lane(
    input logic [quant_pkg::acc_width-1:0] acc,
    input logic [quant_pkg::scale_width-1:0] scale
  );
    logic [quant_pkg::acc_width-1:0] shifted;
    shifted = acc >> scale;
    if (acc[quant_pkg::acc_width-1]) begin
      return '0;
    end else if (|shifted[quant_pkg::acc_width-1:quant_pkg::quant_width]) begin
      return '1;
    end
    return shifted[quant_pkg::quant_width-1:0];
  endfunction

  // lower half runs in both modes, upper half only in dual
  assign lower_live = (in.mode == quant_pkg::mode_single_ch) ||
                      (in.mode == quant_pkg::mode_dual_ch);
  assign upper_live = (in.mode == quant_pkg::mode_dual_ch);

  //////////////////////////////////////////////////////////////////////
  // lane quantizers
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < quant_pkg::lane_num; i++) begin : g_lane
    localparam bit is_upper = (i >= quant_pkg::lanes_per_channel);
    logic [quant_pkg::acc_width-1:0] lane_acc;
    logic [quant_pkg::quant_width-1:0] lane_q;

    assign lane_acc = in.vector[i*quant_pkg::acc_width +: quant_pkg::acc_width];
    assign lane_q = quantize_lane(lane_acc, is_upper ? scale_ch1 : scale_ch0);
    assign quant_vector[i*quant_pkg::quant_width +: quant_pkg::quant_width] =
        (is_upper ? upper_live : lower_live) ? lane_q : '0;
  end

  //////////////////////////////////////////////////////////////////////
  // output register, holds between vectors
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_last <= 1'b0;
      out_vector <= '0;
    end else begin
      out_valid <= in.valid;
      out_last <= in.valid & in.last;
      if (in.valid) begin
        out_vector <= quant_vector;
      end
    end
  end

endmodule

// ==== rtl/bias_add_vec.sv ====
`timescale 1ns/10ps

module bias_add_vec (
  input  logic clk,
  input  logic reset,
  input  logic in_valid,
  input  quant_pkg::mode_t in_mode,
  input  logic in_last,
  input  logic [quant_pkg::acc_vec_width-1:0] in_vector,
  input  quant_pkg::bias_pair_t bias,
  acc_vec_if.producer out
);

  logic [quant_pkg::acc_vec_width-1:0] sum_vector;
  logic signed [quant_pkg::bias_width-1:0] upper_bias;

  // upper half falls back to channel 0 outside dual mode
  assign upper_bias = (in_mode == quant_pkg::mode_dual_ch) ? bias.bias_ch1 : bias.bias_ch0;

  //////////////////////////////////////////////////////////////////////
  // per-lane bias add, wraps at acc_width
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < quant_pkg::lane_num; i++) begin : g_lane
    logic signed [quant_pkg::bias_width-1:0] lane_bias;
    logic [quant_pkg::acc_width-1:0] lane_acc;
    logic [quant_pkg::acc_width-1:0] bias_ext;

    assign lane_bias = (i < quant_pkg::lanes_per_channel) ? bias.bias_ch0 : upper_bias;
    assign lane_acc = in_vector[i*quant_pkg::acc_width +: quant_pkg::acc_width];
    // sign extension to the lane width
    assign bias_ext = {{(quant_pkg::acc_width - quant_pkg::bias_width){lane_bias[
                        quant_pkg::bias_width-1]}}, lane_bias};
    assign sum_vector[i*quant_pkg::acc_width +: quant_pkg::acc_width] = lane_acc + bias_ext;
  end

  //////////////////////////////////////////////////////////////////////
  // stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out.valid <= 1'b0;
      out.last <= 1'b0;
      out.mode <= quant_pkg::mode_single_ch;
    end else begin
      out.valid <= in_valid;
      out.last <= in_valid & in_last;
      if (in_valid) begin
        out.mode <= in_mode;
      end
    end
  end

  // payload only moves with a vector
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out.vector <= sum_vector;
    end
  end

endmodule

// ==== rtl/scale_bias_cfg.sv ====
`timescale 1ns/10ps

module scale_bias_cfg (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  quant_pkg::scale_word_u scale_in,
  input  quant_pkg::bias_pair_t bias_in,
  input  quant_pkg::mode_t mode,
  output logic [quant_pkg::scale_width-1:0] scale_ch0,
  output logic [quant_pkg::scale_width-1:0] scale_ch1,
  output quant_pkg::bias_pair_t cur_bias
);

  quant_pkg::scale_word_u scale_q;
  quant_pkg::bias_pair_t bias_q;

  //////////////////////////////////////////////////////////////////////
  // stored configuration
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      scale_q <= '0;
      bias_q <= '0;
    end else if (load) begin
      scale_q <= scale_in;
      bias_q <= bias_in;
    end
  end

  assign cur_bias = bias_q;

  // decode follows the mode of the vector now in the quantizer
  always_comb begin
    case (mode)
      quant_pkg::mode_single_ch: begin
        // one shift serves both halves
        scale_ch0 = scale_q.single.scale;
        scale_ch1 = scale_q.single.scale;
      end
      quant_pkg::mode_dual_ch: begin
        scale_ch0 = scale_q.dual.scale_ch0;
        scale_ch1 = scale_q.dual.scale_ch1;
      end
      default: begin
        scale_ch0 = '0;
        scale_ch1 = '0;
      end
    endcase
  end

endmodule

// ==== rtl/acc_vec_if.sv ====
`timescale 1ns/10ps

// biased accumulator vector, bias stage to quantizer
interface acc_vec_if;

  logic [quant_pkg::acc_vec_width-1:0] vector;
  logic valid;
  quant_pkg::mode_t mode;
  logic last;

  // no handshake, valid is a one-cycle strobe per vector
  modport producer (
    output vector,
    output valid,
    output mode,
    output last
  );

  modport consumer (
    input vector,
    input valid,
    input mode,
    input last
  );

endinterface

// ==== rtl/quant_pkg.sv ====
package quant_pkg;

  //////////////////////////////////////////////////////////////////////
  // array geometry
  //////////////////////////////////////////////////////////////////////

  // columns of the systolic array
  localparam int column_num_in_sa = 16;
  localparam int pixels_per_col = 2;
  localparam int channel_num = 2;

  // lanes of one channel, then the whole vector
  localparam int lanes_per_channel = column_num_in_sa * pixels_per_col;
  localparam int lane_num = lanes_per_channel * channel_num;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int acc_width = 40;
  localparam int bias_width = 16;
  localparam int scale_width = 8;
  localparam int quant_width = 8;

  localparam int acc_vec_width = lane_num * acc_width;
  localparam int quant_vec_width = lane_num * quant_width;

  // precision mode, follows the array's pixel/weight packing
  typedef enum logic [3:0] {
    mode_single_ch = 4'd0,
    mode_dual_ch   = 4'd1
  } mode_t;

  // two shifts, one per channel
  typedef struct packed {
    logic [scale_width-1:0] scale_ch1;
    logic [scale_width-1:0] scale_ch0;
  } scale_dual_t;

  // one shift, upper byte ignored
  typedef struct packed {
    logic [scale_width-1:0] unused;
    logic [scale_width-1:0] scale;
  } scale_single_t;

  typedef union packed {
    scale_dual_t   dual;
    scale_single_t single;
  } scale_word_u;

  typedef struct packed {
    logic signed [bias_width-1:0] bias_ch1;
    logic signed [bias_width-1:0] bias_ch0;
  } bias_pair_t;

endpackage
